//--- project.f
+incdir+include
rtl/wb_pkg.sv
rtl/csr_timer_if.sv
rtl/trap_if.sv
rtl/wb_latch.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/trap_unit.sv
rtl/wb_stage_top.sv
verification/tb_wb_stage.sv

//--- rtl/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile (
	input  logic              clk,
	input  logic              reset,
	input  logic              retire_valid,
	input  wb_pkg::wb_op_e    retire_op,
	input  wb_pkg::csr_num_t  retire_csr,
	input  wb_pkg::word_t     retire_mask,
	input  wb_pkg::word_t     retire_result,
	input  wb_pkg::word_t     retire_pc,
	output wb_pkg::word_t     csr_rdata,
	csr_timer_if.file         tmr,
	trap_if.file              trp
);

	localparam int PLV_W   = $bits(wb_pkg::plv_t);
	localparam int ECODE_W = $bits(wb_pkg::ecode_t);
	localparam int IS_W    = $bits(wb_pkg::int_vec_t);
	localparam int VS_W    = wb_pkg::ECFG_VS_W;
	localparam int VA_LSB  = wb_pkg::EENTRY_VA_LSB;

	logic                    wr_op;
	logic                    csr_we;
	logic                    ertn_ret;
	logic                    save_sel;
	wb_pkg::word_t           wr_val;

	wb_pkg::plv_t            crmd_plv;
	logic                    crmd_ie;
	wb_pkg::plv_t            prmd_pplv;
	logic                    prmd_pie;
	wb_pkg::int_vec_t        ecfg_lie;
	logic [VS_W-1:0]         ecfg_vs;
	logic [1:0]              estat_is_sw;
	wb_pkg::ecode_t          estat_ecode;
	wb_pkg::word_t           era;
	wb_pkg::word_t           eentry;
	wb_pkg::word_t           tid;
	wb_pkg::word_t           save_r [0:3];
	wb_pkg::int_vec_t        int_lines;

	// Software lines plus the timer line
	always_comb begin
		int_lines = '0;
		int_lines[1:0] = estat_is_sw;
		int_lines[wb_pkg::TIMER_INT_BIT] = tmr.timer_int;
	end

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////
	always_comb begin
		csr_rdata = '0;
		case (retire_csr)
			wb_pkg::CSR_CRMD: begin
				csr_rdata[wb_pkg::CRMD_PLV_LSB +: PLV_W] = crmd_plv;
				csr_rdata[wb_pkg::CRMD_IE_BIT] = crmd_ie;
			end
			wb_pkg::CSR_PRMD: begin
				csr_rdata[wb_pkg::PRMD_PPLV_LSB +: PLV_W] = prmd_pplv;
				csr_rdata[wb_pkg::PRMD_PIE_BIT] = prmd_pie;
			end
			wb_pkg::CSR_ECFG: begin
				csr_rdata[IS_W-1:0] = ecfg_lie;
				csr_rdata[wb_pkg::ECFG_VS_LSB +: VS_W] = ecfg_vs;
			end
			wb_pkg::CSR_ESTAT: begin
				csr_rdata[IS_W-1:0] = int_lines;
				csr_rdata[wb_pkg::ESTAT_ECODE_LSB +: ECODE_W] = estat_ecode;
			end
			wb_pkg::CSR_ERA:    csr_rdata = era;
			wb_pkg::CSR_EENTRY: csr_rdata = eentry;
			wb_pkg::CSR_SAVE0:  csr_rdata = save_r[0];
			wb_pkg::CSR_SAVE1:  csr_rdata = save_r[1];
			wb_pkg::CSR_SAVE2:  csr_rdata = save_r[2];
			wb_pkg::CSR_SAVE3:  csr_rdata = save_r[3];
			wb_pkg::CSR_TID:    csr_rdata = tid;
			wb_pkg::CSR_TCFG:   csr_rdata = tmr.tcfg_value;
			wb_pkg::CSR_TVAL:   csr_rdata = tmr.tval_value;
			default: ;
		endcase
	end

	assign wr_op    = (retire_op == wb_pkg::op_csrwr) || (retire_op == wb_pkg::op_csrxchg);
	assign csr_we   = retire_valid && wr_op && !trp.take_ex;
	assign ertn_ret = retire_valid && (retire_op == wb_pkg::op_ertn) && !trp.take_ex;
	assign save_sel = (retire_csr[13:2] == wb_pkg::CSR_SAVE0[13:2]);

	// csrxchg keeps the old bits outside the mask
	assign wr_val = (retire_op == wb_pkg::op_csrxchg) ?
		((retire_result & retire_mask) | (csr_rdata & ~retire_mask)) : retire_result;

	////////////////////////////////////////////////////////////
	// Control CSRs
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			crmd_plv    <= '0;
			crmd_ie     <= 1'b0;
			ecfg_lie    <= '0;
			ecfg_vs     <= '0;
			estat_is_sw <= '0;
		end else begin
			if (trp.take_ex) begin
				crmd_plv <= '0;
				crmd_ie  <= 1'b0;
			end else if (ertn_ret) begin
				crmd_plv <= prmd_pplv;
				crmd_ie  <= prmd_pie;
			end else if (csr_we && (retire_csr == wb_pkg::CSR_CRMD)) begin
				crmd_plv <= wr_val[wb_pkg::CRMD_PLV_LSB +: PLV_W];
				crmd_ie  <= wr_val[wb_pkg::CRMD_IE_BIT];
			end

			if (csr_we && (retire_csr == wb_pkg::CSR_ECFG)) begin
				ecfg_lie <= wr_val[IS_W-1:0] & wb_pkg::LIE_MASK;
				ecfg_vs  <= wr_val[wb_pkg::ECFG_VS_LSB +: VS_W];
			end

			if (csr_we && (retire_csr == wb_pkg::CSR_ESTAT)) begin
				estat_is_sw <= wr_val[1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Saved state and scratch CSRs
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (trp.take_ex) begin
			prmd_pplv   <= crmd_plv;
			prmd_pie    <= crmd_ie;
			era         <= retire_pc;
			estat_ecode <= trp.ex_code;
		end else if (csr_we) begin
			if (retire_csr == wb_pkg::CSR_PRMD) begin
				prmd_pplv <= wr_val[wb_pkg::PRMD_PPLV_LSB +: PLV_W];
				prmd_pie  <= wr_val[wb_pkg::PRMD_PIE_BIT];
			end
			if (retire_csr == wb_pkg::CSR_ERA) begin
				era <= wr_val;
			end
			if (retire_csr == wb_pkg::CSR_ESTAT) begin
				estat_ecode <= wr_val[wb_pkg::ESTAT_ECODE_LSB +: ECODE_W];
			end
		end

		if (csr_we && (retire_csr == wb_pkg::CSR_EENTRY)) begin
			eentry <= {wr_val[31:VA_LSB], {VA_LSB{1'b0}}};
		end
		if (csr_we && (retire_csr == wb_pkg::CSR_TID)) begin
			tid <= wr_val;
		end
		if (csr_we && save_sel) begin
			save_r[retire_csr[1:0]] <= wr_val;
		end
	end

	assign tmr.csr_wr   = csr_we;
	assign tmr.csr_num  = retire_csr;
	assign tmr.wr_value = wr_val;

	assign trp.int_lines  = int_lines;
	assign trp.int_enable = crmd_ie;
	assign trp.int_mask   = ecfg_lie;
	assign trp.eentry     = eentry;
	assign trp.ecfg_vs    = ecfg_vs;
	assign trp.era        = era;

endmodule

//--- rtl/csr_timer.sv
`timescale 1ns/100ps

module csr_timer (
	input  logic      clk,
	input  logic      reset,
	csr_timer_if.timer tmr
);

	localparam int INIT_LSB = wb_pkg::TCFG_INITVAL_LSB;

	wb_pkg::word_t  tcfg;
	wb_pkg::word_t  tval;
	logic           armed;
	logic           timer_int;
	logic           tcfg_wr;
	logic           ticlr_clr;
	logic           timer_en;
	logic           expire;
	wb_pkg::word_t  wr_reload;
	wb_pkg::word_t  cfg_reload;

	assign tcfg_wr   = tmr.csr_wr && (tmr.csr_num == wb_pkg::CSR_TCFG);
	assign ticlr_clr = tmr.csr_wr && (tmr.csr_num == wb_pkg::CSR_TICLR) && tmr.wr_value[0];

	assign timer_en = tcfg[wb_pkg::TCFG_EN_BIT];
	assign expire   = timer_en && armed && (tval == '0);

	// Initial value times 4
	assign wr_reload  = {tmr.wr_value[31:INIT_LSB], {INIT_LSB{1'b0}}};
	assign cfg_reload = {tcfg[31:INIT_LSB], {INIT_LSB{1'b0}}};

	always_ff @(posedge clk) begin
		if (reset) begin
			tcfg      <= '0;
			armed     <= 1'b0;
			timer_int <= 1'b0;
		end else begin
			if (tcfg_wr) begin
				tcfg  <= tmr.wr_value;
				armed <= tmr.wr_value[wb_pkg::TCFG_EN_BIT];
			end else if (expire && !tcfg[wb_pkg::TCFG_PERIODIC_BIT]) begin
				armed <= 1'b0;
			end

			// Clear wins over a new expiry
			if (ticlr_clr) begin
				timer_int <= 1'b0;
			end else if (expire) begin
				timer_int <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tcfg_wr) begin
			tval <= wr_reload;
		end else if (timer_en && (tval != '0)) begin
			tval <= tval - 1'b1;
		end else if (expire && tcfg[wb_pkg::TCFG_PERIODIC_BIT]) begin
			tval <= cfg_reload;
		end
	end

	assign tmr.tcfg_value = tcfg;
	assign tmr.tval_value = tval;
	assign tmr.timer_int  = timer_int;

endmodule

//--- rtl/csr_timer_if.sv
`timescale 1ns/100ps

interface csr_timer_if;

	// Write side, one pulse per retiring CSR write
	logic              csr_wr;
	wb_pkg::csr_num_t  csr_num;
	wb_pkg::word_t     wr_value;

	// Timer readback
	wb_pkg::word_t     tcfg_value;
	wb_pkg::word_t     tval_value;
	logic              timer_int;

	modport file (
		output csr_wr,
		output csr_num,
		output wr_value,
		input  tcfg_value,
		input  tval_value,
		input  timer_int
	);

	modport timer (
		input  csr_wr,
		input  csr_num,
		input  wr_value,
		output tcfg_value,
		output tval_value,
		output timer_int
	);

endinterface

//--- rtl/trap_if.sv
`timescale 1ns/100ps

interface trap_if;

	wb_pkg::int_vec_t                int_lines;
	logic                            int_enable;
	wb_pkg::int_vec_t                int_mask;
	wb_pkg::word_t                   eentry;
	logic [wb_pkg::ECFG_VS_W-1:0]    ecfg_vs;
	wb_pkg::word_t                   era;

	// Trap decision back to the CSR file
	logic                            take_ex;
	wb_pkg::ecode_t                  ex_code;

	modport file (
		output int_lines,
		output int_enable,
		output int_mask,
		output eentry,
		output ecfg_vs,
		output era,
		input  take_ex,
		input  ex_code
	);

	modport unit (
		input  int_lines,
		input  int_enable,
		input  int_mask,
		input  eentry,
		input  ecfg_vs,
		input  era,
		output take_ex,
		output ex_code
	);

endinterface

//--- rtl/trap_unit.sv
`timescale 1ns/100ps

module trap_unit (
	input  logic            retire_valid,
	input  wb_pkg::wb_op_e  retire_op,
	input  logic            retire_ex,
	input  wb_pkg::ecode_t  retire_ecode,
	output logic            take_ex,
	output logic            take_ertn,
	output logic            redirect_valid,
	output wb_pkg::word_t   redirect_pc,
	output logic            flush,
	trap_if.unit            trp
);

	logic            int_hit;
	wb_pkg::ecode_t  ex_code;
	wb_pkg::word_t   ex_entry;

	// Pending and enabled lines, globally enabled by CRMD.IE
	assign int_hit = (|(trp.int_lines & trp.int_mask)) && trp.int_enable;

	assign take_ex   = retire_valid && (int_hit || retire_ex);
	assign take_ertn = retire_valid && (retire_op == wb_pkg::op_ertn) && !take_ex;

	// Interrupt overrides the instruction's own code
	assign ex_code = int_hit ? wb_pkg::ECODE_INT : retire_ecode;

	////////////////////////////////////////////////////////////
	// Redirect target
	////////////////////////////////////////////////////////////
	always_comb begin
		if (trp.ecfg_vs == '0) begin
			ex_entry = trp.eentry;
		end else begin
			ex_entry = trp.eentry | (wb_pkg::word_t'(ex_code) << 2);
		end
	end

	assign redirect_valid = take_ex || take_ertn;
	assign redirect_pc    = take_ertn ? trp.era : ex_entry;

	// Younger stages are squashed on any redirect
	assign flush = take_ex || take_ertn;

	assign trp.take_ex = take_ex;
	assign trp.ex_code = ex_code;

endmodule

//--- rtl/wb_latch.sv
`timescale 1ns/100ps

module wb_latch (
	input  logic              clk,
	input  logic              reset,
	input  logic              ms_valid,
	input  wb_pkg::word_t     ms_pc,
	input  wb_pkg::word_t     ms_result,
	input  wb_pkg::reg_idx_t  ms_dest,
	input  logic              ms_gr_we,
	input  wb_pkg::wb_op_e    ms_op,
	input  wb_pkg::csr_num_t  ms_csr,
	input  wb_pkg::word_t     ms_mask,
	input  logic              ms_ex,
	input  wb_pkg::ecode_t    ms_ecode,
	input  wb_pkg::word_t     csr_rdata,
	input  logic              take_ex,
	input  logic              take_ertn,
	output logic              retire_valid,
	output wb_pkg::wb_op_e    retire_op,
	output wb_pkg::csr_num_t  retire_csr,
	output wb_pkg::word_t     retire_mask,
	output wb_pkg::word_t     retire_pc,
	output wb_pkg::word_t     retire_result,
	output logic              retire_ex,
	output wb_pkg::ecode_t    retire_ecode,
	output logic              rf_we,
	output wb_pkg::reg_idx_t  rf_waddr,
	output wb_pkg::word_t     rf_wdata
);

	logic              ws_valid;
	wb_pkg::reg_idx_t  ws_dest;
	logic              ws_gr_we;
	logic              is_csr_op;

	// Item offered during a trap or ertn is dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			ws_valid <= 1'b0;
		end else begin
			ws_valid <= ms_valid && !(take_ex || take_ertn);
		end
	end

	always_ff @(posedge clk) begin
		if (ms_valid) begin
			retire_pc     <= ms_pc;
			retire_result <= ms_result;
			ws_dest       <= ms_dest;
			ws_gr_we      <= ms_gr_we;
			retire_op     <= ms_op;
			retire_csr    <= ms_csr;
			retire_mask   <= ms_mask;
			retire_ex     <= ms_ex;
			retire_ecode  <= ms_ecode;
		end
	end

	assign retire_valid = ws_valid;

	assign is_csr_op = (retire_op == wb_pkg::op_csrrd) ||
		(retire_op == wb_pkg::op_csrwr) ||
		(retire_op == wb_pkg::op_csrxchg);

	// CSR instructions return the old CSR value
	assign rf_we    = ws_valid && ws_gr_we && !take_ex;
	assign rf_waddr = ws_dest;
	assign rf_wdata = is_csr_op ? csr_rdata : retire_result;

endmodule

//--- rtl/wb_pkg.sv
package wb_pkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [13:0] csr_num_t;
	typedef logic [5:0]  ecode_t;
	typedef logic [1:0]  plv_t;
	// SWI in 1:0, timer in 11, bit 10 reads zero
	typedef logic [12:0] int_vec_t;

	typedef enum logic [2:0] {
		op_none,
		op_csrrd,
		op_csrwr,
		op_csrxchg,
		op_ertn
	} wb_op_e;

	////////////////////////////////////////////////////////////
	// CSR numbers
	////////////////////////////////////////////////////////////
	localparam csr_num_t CSR_CRMD   = 14'h000;
	localparam csr_num_t CSR_PRMD   = 14'h001;
	localparam csr_num_t CSR_ECFG   = 14'h004;
	localparam csr_num_t CSR_ESTAT  = 14'h005;
	localparam csr_num_t CSR_ERA    = 14'h006;
	localparam csr_num_t CSR_EENTRY = 14'h00c;
	localparam csr_num_t CSR_SAVE0  = 14'h030;
	localparam csr_num_t CSR_SAVE1  = 14'h031;
	localparam csr_num_t CSR_SAVE2  = 14'h032;
	localparam csr_num_t CSR_SAVE3  = 14'h033;
	localparam csr_num_t CSR_TID    = 14'h040;
	localparam csr_num_t CSR_TCFG   = 14'h041;
	localparam csr_num_t CSR_TVAL   = 14'h042;
	localparam csr_num_t CSR_TICLR  = 14'h044;

	localparam ecode_t   ECODE_INT     = 6'h00;
	localparam int       TIMER_INT_BIT = 11;
	localparam int_vec_t LIE_MASK      = 13'h1bff;

	////////////////////////////////////////////////////////////
	// Field positions
	////////////////////////////////////////////////////////////
	localparam int CRMD_PLV_LSB      = 0;
	localparam int CRMD_IE_BIT       = 2;
	localparam int PRMD_PPLV_LSB     = 0;
	localparam int PRMD_PIE_BIT      = 2;
	localparam int ECFG_VS_LSB       = 16;
	localparam int ECFG_VS_W         = 3;
	localparam int ESTAT_ECODE_LSB   = 16;
	localparam int EENTRY_VA_LSB     = 12;
	localparam int TCFG_EN_BIT       = 0;
	localparam int TCFG_PERIODIC_BIT = 1;
	localparam int TCFG_INITVAL_LSB  = 2;

endpackage

//--- rtl/wb_stage_top.sv
`timescale 1ns/100ps

module wb_stage_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              ms_valid,
	input  wb_pkg::word_t     ms_pc,
	input  wb_pkg::word_t     ms_result,
	input  wb_pkg::reg_idx_t  ms_dest,
	input  logic              ms_gr_we,
	input  wb_pkg::wb_op_e    ms_op,
	input  wb_pkg::csr_num_t  ms_csr,
	input  wb_pkg::word_t     ms_mask,
	input  logic              ms_ex,
	input  wb_pkg::ecode_t    ms_ecode,
	output logic              rf_we,
	output wb_pkg::reg_idx_t  rf_waddr,
	output wb_pkg::word_t     rf_wdata,
	output logic              redirect_valid,
	output wb_pkg::word_t     redirect_pc,
	output logic              flush
);

	logic              retire_valid;
	wb_pkg::wb_op_e    retire_op;
	wb_pkg::csr_num_t  retire_csr;
	wb_pkg::word_t     retire_mask;
	wb_pkg::word_t     retire_pc;
	wb_pkg::word_t     retire_result;
	logic              retire_ex;
	wb_pkg::ecode_t    retire_ecode;
	wb_pkg::word_t     csr_rdata;
	logic              take_ex;
	logic              take_ertn;

	csr_timer_if u_tmr_if ();
	trap_if      u_trap_if ();

	wb_latch u_latch (
		.clk           (clk),
		.reset         (reset),
		.ms_valid      (ms_valid),
		.ms_pc         (ms_pc),
		.ms_result     (ms_result),
		.ms_dest       (ms_dest),
		.ms_gr_we      (ms_gr_we),
		.ms_op         (ms_op),
		.ms_csr        (ms_csr),
		.ms_mask       (ms_mask),
		.ms_ex         (ms_ex),
		.ms_ecode      (ms_ecode),
		.csr_rdata     (csr_rdata),
		.take_ex       (take_ex),
		.take_ertn     (take_ertn),
		.retire_valid  (retire_valid),
		.retire_op     (retire_op),
		.retire_csr    (retire_csr),
		.retire_mask   (retire_mask),
		.retire_pc     (retire_pc),
		.retire_result (retire_result),
		.retire_ex     (retire_ex),
		.retire_ecode  (retire_ecode),
		.rf_we         (rf_we),
		.rf_waddr      (rf_waddr),
		.rf_wdata      (rf_wdata)
	);

	csr_regfile u_csr (
		.clk           (clk),
		.reset         (reset),
		.retire_valid  (retire_valid),
		.retire_op     (retire_op),
		.retire_csr    (retire_csr),
		.retire_mask   (retire_mask),
		.retire_result (retire_result),
		.retire_pc     (retire_pc),
		.csr_rdata     (csr_rdata),
		.tmr           (u_tmr_if.file),
		.trp           (u_trap_if.file)
	);

	csr_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.tmr   (u_tmr_if.timer)
	);

	trap_unit u_trap (
		.retire_valid   (retire_valid),
		.retire_op      (retire_op),
		.retire_ex      (retire_ex),
		.retire_ecode   (retire_ecode),
		.take_ex        (take_ex),
		.take_ertn      (take_ertn),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.flush          (flush),
		.trp            (u_trap_if.unit)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the write-back stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module tb_wb_stage -f project.f || exit 1

sim_out="$(./obj_dir/Vtb_wb_stage 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "^SIMULATION PASSED$" && exit 0 || exit 1

//--- include/tb_vectors.svh
// One call per item, in the order the items are offered.
// Expected values belong to the retiring cycle that follows.
task automatic load_vectors();
	wb_pkg::word_t entry;
	wb_pkg::word_t trap_pc;
	wb_pkg::word_t val_b;
	wb_pkg::word_t val_c;
	wb_pkg::word_t mask_m;
	entry  = 32'h1c00_8000;
	val_b  = 32'haaaa_5555;
	val_c  = 32'hcccc_3333;
	mask_m = 32'h00ff_ff00;
	n_rows = 0;

	// Plain write back
	plain_item(32'h0000_00a5, 1'b1);
	bubble();

	// Scratch CSRs and the csrxchg merge
	write_csr(wb_pkg::CSR_SAVE0, 32'h1234_5678);
	read_csr(wb_pkg::CSR_SAVE0, 32'h1234_5678);
	write_csr(wb_pkg::CSR_SAVE1, val_c);
	exchange_csr(wb_pkg::CSR_SAVE1, val_b, mask_m, val_c);
	// Masked middle bytes from B, outer bytes kept from C
	read_csr(wb_pkg::CSR_SAVE1, 32'hccaa_5533);

	// Vectored entry with VS = 1
	write_csr(wb_pkg::CSR_EENTRY, entry);
	write_csr(wb_pkg::CSR_ECFG, 32'h0001_0000);
	// Ecode 8 lands at offset 0x20
	trap_item(1'b1, 6'h08, 32'h1c00_8020);
	// Offered in the trap cycle and dropped
	plain_item(32'hdead_beef, 1'b0);

	// Common entry with VS = 0 taken from PLV 3
	write_csr(wb_pkg::CSR_ECFG, 32'h0);
	write_csr(wb_pkg::CSR_CRMD, 32'h0000_0003);
	trap_pc = pc_of(n_rows);
	trap_item(1'b1, 6'h0b, entry);
	plain_item(32'hdead_beef, 1'b0);
	read_csr(wb_pkg::CSR_ERA, trap_pc);
	read_csr(wb_pkg::CSR_PRMD, 32'h0000_0003);
	read_csr(wb_pkg::CSR_ESTAT, 32'h000b_0000);
	read_csr(wb_pkg::CSR_CRMD, 32'h0);

	// Return to the trapping pc at PLV 3
	ertn_item(trap_pc);
	bubble();
	read_csr(wb_pkg::CSR_CRMD, 32'h0000_0003);

	// One-shot timer with initial value 4 on line 11
	write_csr(wb_pkg::CSR_ECFG, 32'h0000_0800);
	write_csr(wb_pkg::CSR_TCFG, (32'd4 << 2) | 32'h1);
	split_row = n_rows;

	// Interrupt taken once CRMD.IE is set
	write_csr(wb_pkg::CSR_CRMD, 32'h0000_0004);
	trap_pc = pc_of(n_rows);
	// Item carries its own ecode, the interrupt must replace it
	trap_item(1'b0, 6'h08, entry);
	plain_item(32'hdead_beef, 1'b0);
	read_csr(wb_pkg::CSR_ESTAT, 32'h0000_0800);
	read_csr(wb_pkg::CSR_ERA, trap_pc);
	write_csr(wb_pkg::CSR_TICLR, 32'h1);
	read_csr(wb_pkg::CSR_ESTAT, 32'h0);
endtask

//--- verification/tb_wb_stage.sv
`timescale 1ns/100ps

module tb_wb_stage;

	localparam int MAX_ROWS   = 64;
	localparam int POLL_LIMIT = 200;
	localparam wb_pkg::word_t PC_BASE = 32'h1c00_0000;

	typedef struct packed {
		logic              valid;
		wb_pkg::wb_op_e    op;
		wb_pkg::csr_num_t  csr;
		wb_pkg::word_t     value;
		wb_pkg::word_t     mask;
		logic              gr_we;
		logic              ex;
		wb_pkg::ecode_t    ecode;
		logic              exp_we;
		wb_pkg::word_t     exp_wdata;
		logic              exp_redir;
		wb_pkg::word_t     exp_rpc;
	} vec_t;

	logic              clk;
	logic              reset;
	logic              ms_valid;
	wb_pkg::word_t     ms_pc;
	wb_pkg::word_t     ms_result;
	wb_pkg::reg_idx_t  ms_dest;
	logic              ms_gr_we;
	wb_pkg::wb_op_e    ms_op;
	wb_pkg::csr_num_t  ms_csr;
	wb_pkg::word_t     ms_mask;
	logic              ms_ex;
	wb_pkg::ecode_t    ms_ecode;
	logic              rf_we;
	wb_pkg::reg_idx_t  rf_waddr;
	wb_pkg::word_t     rf_wdata;
	logic              redirect_valid;
	wb_pkg::word_t     redirect_pc;
	logic              flush;

	vec_t tbl [0:MAX_ROWS-1];
	int   n_rows;
	int   split_row;
	int   pass_count;
	int   fail_count;
	logic timer_seen;

	wb_stage_top u_wb_stage_top (.*);

	always #4 clk = ~clk;

	function automatic wb_pkg::word_t pc_of(input int idx);
		return PC_BASE + 32'(idx) * 32'd4;
	endfunction

	////////////////////////////////////////////////////////////
	// Table building
	////////////////////////////////////////////////////////////
	task automatic push_row(input logic valid, input wb_pkg::wb_op_e op,
		input wb_pkg::csr_num_t csr, input wb_pkg::word_t value, input wb_pkg::word_t mask,
		input logic gr_we, input logic ex, input wb_pkg::ecode_t ecode, input logic exp_we,
		input wb_pkg::word_t exp_wdata, input logic exp_redir, input wb_pkg::word_t exp_rpc);
		tbl[n_rows] = '{valid, op, csr, value, mask, gr_we, ex, ecode,
			exp_we, exp_wdata, exp_redir, exp_rpc};
		n_rows++;
	endtask

	task automatic plain_item(input wb_pkg::word_t result, input logic exp_we);
		push_row(1'b1, wb_pkg::op_none, '0, result, '0, 1'b1, 1'b0, '0, exp_we, result, 1'b0, '0);
	endtask

	task automatic bubble();
		push_row(1'b0, wb_pkg::op_none, '0, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic write_csr(input wb_pkg::csr_num_t csr, input wb_pkg::word_t value);
		push_row(1'b1, wb_pkg::op_csrwr, csr, value, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic read_csr(input wb_pkg::csr_num_t csr, input wb_pkg::word_t expected);
		push_row(1'b1, wb_pkg::op_csrrd, csr, '0, '0, 1'b1, 1'b0, '0, 1'b1, expected, 1'b0, '0);
	endtask

	task automatic exchange_csr(input wb_pkg::csr_num_t csr, input wb_pkg::word_t value,
		input wb_pkg::word_t mask, input wb_pkg::word_t old);
		push_row(1'b1, wb_pkg::op_csrxchg, csr, value, mask, 1'b1, 1'b0, '0, 1'b1, old, 1'b0, '0);
	endtask

	// Writes nothing, redirects to target
	task automatic trap_item(input logic ex, input wb_pkg::ecode_t ecode,
		input wb_pkg::word_t target);
		push_row(1'b1, wb_pkg::op_none, '0, 32'hbad0_0000, '0, 1'b1, ex, ecode,
			1'b0, '0, 1'b1, target);
	endtask

	task automatic ertn_item(input wb_pkg::word_t target);
		push_row(1'b1, wb_pkg::op_ertn, '0, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b1, target);
	endtask

	`include "tb_vectors.svh"

	////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////
	task automatic drive_row(input int idx);
		ms_valid  = tbl[idx].valid;
		ms_pc     = pc_of(idx);
		ms_result = tbl[idx].value;
		ms_dest   = wb_pkg::reg_idx_t'(idx);
		ms_gr_we  = tbl[idx].gr_we;
		ms_op     = tbl[idx].op;
		ms_csr    = tbl[idx].csr;
		ms_mask   = tbl[idx].mask;
		ms_ex     = tbl[idx].ex;
		ms_ecode  = tbl[idx].ecode;
	endtask

	task automatic check_row(input int idx);
		logic bad;
		bad = 1'b0;
		if (rf_we !== tbl[idx].exp_we)
			bad = 1'b1;
		if (tbl[idx].exp_we && (rf_wdata !== tbl[idx].exp_wdata))
			bad = 1'b1;
		if (tbl[idx].exp_we && (rf_waddr !== wb_pkg::reg_idx_t'(idx)))
			bad = 1'b1;
		if ((redirect_valid !== tbl[idx].exp_redir) || (flush !== tbl[idx].exp_redir))
			bad = 1'b1;
		if (tbl[idx].exp_redir && (redirect_pc !== tbl[idx].exp_rpc))
			bad = 1'b1;
		if (bad) begin
			fail_count++;
			$display("FAIL %0t: row %0d got we=%b wdata=%h redir=%b pc=%h, want %b %h %b %h",
				$time, idx, rf_we, rf_wdata, redirect_valid, redirect_pc,
				tbl[idx].exp_we, tbl[idx].exp_wdata, tbl[idx].exp_redir, tbl[idx].exp_rpc);
		end else begin
			pass_count++;
			$display("ok   row %0d", idx);
		end
	endtask

	// Items overlap, each checked while the next is offered
	task automatic run_rows(input int first, input int last);
		for (int i = first; i <= last; i++) begin
			@(posedge clk);
			#1;
			if (i > first)
				check_row(i - 1);
			drive_row(i);
		end
		@(posedge clk);
		#1;
		check_row(last);
		ms_valid = 1'b0;
	endtask

	task automatic poll_timer(output logic seen);
		int polls;
		seen  = 1'b0;
		polls = 0;
		while (!seen && (polls < POLL_LIMIT)) begin
			@(posedge clk);
			#1;
			ms_valid = 1'b1;
			ms_op    = wb_pkg::op_csrrd;
			ms_csr   = wb_pkg::CSR_ESTAT;
			ms_gr_we = 1'b1;
			ms_ex    = 1'b0;
			@(posedge clk);
			#1;
			ms_valid = 1'b0;
			polls++;
			if (rf_we !== 1'b1) begin
				fail_count++;
				$display("FAIL %0t: ESTAT poll %0d gave no register write", $time, polls);
			end else if (rf_wdata[wb_pkg::TIMER_INT_BIT] === 1'b1) begin
				seen = 1'b1;
			end
		end
		if (seen) begin
			pass_count++;
			$display("ok   timer interrupt pending after %0d polls", polls);
		end
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		ms_valid   = 1'b0;
		ms_pc      = '0;
		ms_result  = '0;
		ms_dest    = '0;
		ms_gr_we   = 1'b0;
		ms_op      = wb_pkg::op_none;
		ms_csr     = '0;
		ms_mask    = '0;
		ms_ex      = 1'b0;
		ms_ecode   = '0;
		pass_count = 0;
		fail_count = 0;
		load_vectors();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if ((rf_we !== 1'b0) || (redirect_valid !== 1'b0) || (flush !== 1'b0)) begin
			fail_count++;
			$display("FAIL %0t: outputs not idle after reset", $time);
		end else begin
			pass_count++;
			$display("ok   reset state");
		end
		run_rows(0, split_row - 1);
		poll_timer(timer_seen);
		if (!timer_seen) begin
			$display("Timeout: timer interrupt never showed up in ESTAT after %0d polls",
				POLL_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			run_rows(split_row, n_rows - 1);
			$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
			if (fail_count == 0) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule
